// File: Bender.yml
package:
  name: gmii_udp_tx

sources:
  - include_dirs:
      - logic
    files:
      - logic/udp_tx_pkg.sv
      - logic/frame_sequencer.sv
      - logic/header_builder.sv
      - logic/sample_packer.sv
      - logic/fcs_appender.sv
      - logic/gmii_udp_tx.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tb_gmii_udp_tx.sv

// File: files.f
+incdir+logic
logic/udp_tx_pkg.sv
logic/frame_sequencer.sv
logic/header_builder.sv
logic/sample_packer.sv
logic/fcs_appender.sv
logic/gmii_udp_tx.sv
sim/tb_gmii_udp_tx.sv

// File: logic/fcs_appender.sv
`timescale 1ns/1ps
`default_nettype none

module fcs_appender (
	input  wire logic                 tx_clk,
	input  wire logic                 sys_rst,
	input  wire udp_tx_pkg::tx_beat_t body,
	output logic                      tx_en,
	output udp_tx_pkg::byte_t         txd
);

	udp_tx_pkg::crc_t crc;
	udp_tx_pkg::crc_t crc_next;
	logic             en_d;
	logic [1:0]       fcs_left;
	logic [23:0]      fcs_sh;

	// Reflected CRC-32 over one byte with the LSB first
	function automatic udp_tx_pkg::crc_t crc_byte(input udp_tx_pkg::crc_t c,
		input udp_tx_pkg::byte_t d);
		udp_tx_pkg::crc_t r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ 32'hedb88320;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	assign crc_next = crc_byte(body.crc_first ? 32'hffffffff : crc, body.data);

	always_ff @(posedge tx_clk) begin
		if (sys_rst) begin
			tx_en    <= 1'b0;
			txd      <= '0;
			en_d     <= 1'b0;
			crc      <= 32'hffffffff;
			fcs_left <= 2'd0;
			fcs_sh   <= '0;
		end else begin
			en_d <= body.en;
			if (body.en) begin
				tx_en <= 1'b1;
				txd   <= body.data;
				crc   <= crc_next;
			end else if (en_d) begin
				// Body just ended so the FCS low byte goes first
				tx_en    <= 1'b1;
				txd      <= ~crc[7:0];
				fcs_sh   <= ~crc[31:8];
				fcs_left <= 2'd3;
			end else if (fcs_left != 2'd0) begin
				tx_en    <= 1'b1;
				txd      <= fcs_sh[7:0];
				fcs_sh   <= fcs_sh >> 8;
				fcs_left <= fcs_left - 2'd1;
			end else begin
				tx_en <= 1'b0;
				txd   <= '0;
			end
		end
	end

	a_no_body_in_fcs: assert property (@(posedge tx_clk) disable iff (sys_rst)
		body.en |-> fcs_left == 2'd0);

endmodule

`default_nettype wire

// File: logic/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_defs.svh"

module frame_sequencer (
	input  wire logic                 tx_clk,
	input  wire logic                 sys_rst,
	input  wire logic                 empty,
	input  wire udp_tx_pkg::byte_t    hdr_byte,
	input  wire udp_tx_pkg::byte_t    pay_byte,
	output udp_tx_pkg::hdr_idx_t      hdr_idx,
	output logic                      frame_start,
	output logic                      pay_arm,
	output logic                      pay_adv,
	output udp_tx_pkg::tx_beat_t      body
);

	udp_tx_pkg::seq_state_e state;
	udp_tx_pkg::pay_cnt_t   cnt;
	udp_tx_pkg::tx_beat_t   beat_next;

	// ---------------------------------------------------------------------
	// Strobes to the builder and packer
	// ---------------------------------------------------------------------

	// Header index is the section counter
	assign hdr_idx = cnt[5:0];

	// Checksum is latched as the frame is committed
	assign frame_start = (state == udp_tx_pkg::seq_idle) && !empty;

	// Two cycles ahead of payload byte 0
	assign pay_arm = (state == udp_tx_pkg::seq_header) &&
		(cnt == udp_tx_pkg::pay_cnt_t'(40));

	assign pay_adv = (state == udp_tx_pkg::seq_payload);

	// ---------------------------------------------------------------------
	// Byte source select
	// ---------------------------------------------------------------------

	always_comb begin
		beat_next = '0;
		case (state)
			udp_tx_pkg::seq_preamble: begin
				beat_next.en   = 1'b1;
				beat_next.data = 8'h55;
			end
			udp_tx_pkg::seq_sfd: begin
				beat_next.en   = 1'b1;
				beat_next.data = 8'hd5;
			end
			udp_tx_pkg::seq_header: begin
				beat_next.en        = 1'b1;
				beat_next.data      = hdr_byte;
				// CRC covers everything from the first MAC byte on
				beat_next.crc_first = (cnt == '0);
			end
			udp_tx_pkg::seq_payload: begin
				beat_next.en   = 1'b1;
				beat_next.data = pay_byte;
			end
			default: begin
				beat_next = '0;
			end
		endcase
	end

	// ---------------------------------------------------------------------
	// Section FSM
	// ---------------------------------------------------------------------

	always_ff @(posedge tx_clk) begin
		if (sys_rst) begin
			state <= udp_tx_pkg::seq_idle;
			cnt   <= '0;
			body  <= '0;
		end else begin
			body <= beat_next;
			case (state)
				udp_tx_pkg::seq_idle: begin
					cnt <= '0;
					if (!empty)
						state <= udp_tx_pkg::seq_preamble;
				end
				udp_tx_pkg::seq_preamble: begin
					if (cnt == udp_tx_pkg::pay_cnt_t'(`UDP_TX_PREAMBLE_LEN - 1)) begin
						cnt   <= '0;
						state <= udp_tx_pkg::seq_sfd;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				udp_tx_pkg::seq_sfd: begin
					cnt   <= '0;
					state <= udp_tx_pkg::seq_header;
				end
				udp_tx_pkg::seq_header: begin
					if (cnt == udp_tx_pkg::pay_cnt_t'(41)) begin
						cnt   <= '0;
						state <= udp_tx_pkg::seq_payload;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				udp_tx_pkg::seq_payload: begin
					if (cnt == udp_tx_pkg::pay_cnt_t'(`UDP_TX_PAYLOAD_BYTES - 1)) begin
						cnt   <= '0;
						state <= udp_tx_pkg::seq_gap;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				udp_tx_pkg::seq_gap: begin
					// Four FCS bytes go out at the start of the gap
					if (cnt == udp_tx_pkg::pay_cnt_t'(4 + `UDP_TX_IFG_CYCLES - 1)) begin
						cnt   <= '0;
						state <= udp_tx_pkg::seq_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					cnt   <= '0;
					state <= udp_tx_pkg::seq_idle;
				end
			endcase
		end
	end

	// Payload advance only in its window with the first byte armed two cycles earlier
	a_pay_adv_window: assert property (@(posedge tx_clk) disable iff (sys_rst)
		pay_adv |-> (state == udp_tx_pkg::seq_payload) &&
			(cnt != '0 || $past(pay_arm, 2)));

endmodule

`default_nettype wire

// File: logic/gmii_udp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_udp_tx (
	input  wire logic                tx_clk,
	input  wire logic                sys_rst,
	input  wire logic                id,
	input  wire udp_tx_pkg::sample_t sample,
	input  wire logic                empty,
	output logic                     rd_en,
	output logic                     tx_en,
	output udp_tx_pkg::byte_t        txd
);

	udp_tx_pkg::hdr_idx_t hdr_idx;
	udp_tx_pkg::byte_t    hdr_byte;
	udp_tx_pkg::byte_t    pay_byte;
	udp_tx_pkg::tx_beat_t body;
	logic                 frame_start;
	logic                 pay_arm;
	logic                 pay_adv;

	frame_sequencer i_frame_sequencer (
		.tx_clk, .sys_rst, .empty, .hdr_byte, .pay_byte,
		.hdr_idx, .frame_start, .pay_arm, .pay_adv, .body
	);

	header_builder i_header_builder (
		.tx_clk, .sys_rst, .id, .frame_start, .hdr_idx, .hdr_byte
	);

	sample_packer i_sample_packer (
		.tx_clk, .sys_rst, .pay_arm, .pay_adv, .sample, .rd_en, .pay_byte
	);

	// Output register and FCS tail
	fcs_appender i_fcs_appender (
		.tx_clk, .sys_rst, .body, .tx_en, .txd
	);

endmodule

`default_nettype wire

// File: logic/header_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_defs.svh"

module header_builder (
	input  wire logic                 tx_clk,
	input  wire logic                 sys_rst,
	input  wire logic                 id,
	input  wire logic                 frame_start,
	input  wire udp_tx_pkg::hdr_idx_t hdr_idx,
	output udp_tx_pkg::byte_t         hdr_byte
);

	logic [47:0]  dst_mac_base;
	logic [47:0]  src_mac_base;
	logic [31:0]  dst_ip_base;
	logic [31:0]  src_ip_base;
	logic [47:0]  dst_mac;
	logic [47:0]  src_mac;
	logic [31:0]  dst_ip;
	logic [31:0]  src_ip;
	logic [19:0]  word_sum;
	logic [16:0]  fold_lo;
	logic [15:0]  fold_hi;
	logic [15:0]  ip_cks;
	logic [335:0] hdr_vec;

	assign dst_mac_base = `UDP_TX_DST_MAC;
	assign src_mac_base = `UDP_TX_SRC_MAC;
	assign dst_ip_base  = `UDP_TX_DST_IP;
	assign src_ip_base  = `UDP_TX_SRC_IP;

	// Station id moves only the low byte
	assign dst_mac = {dst_mac_base[47:8], dst_mac_base[7:0] - {7'd0, id}};
	assign src_mac = {src_mac_base[47:8], src_mac_base[7:0] + {7'd0, id}};
	assign dst_ip  = {dst_ip_base[31:8], dst_ip_base[7:0] - {7'd0, id}};
	assign src_ip  = {src_ip_base[31:8], src_ip_base[7:0] + {7'd0, id}};

	// ---------------------------------------------------------------------
	// IPv4 header checksum
	// ---------------------------------------------------------------------

	// Eight nonzero words since ident and checksum count as zero
	assign word_sum = 20'h04500 + {4'd0, `UDP_TX_IP_LEN} + 20'h04000 +
		{4'd0, `UDP_TX_TTL, 8'h11} +
		{4'd0, src_ip[31:16]} + {4'd0, src_ip[15:0]} +
		{4'd0, dst_ip[31:16]} + {4'd0, dst_ip[15:0]};

	// End-around carry in two steps
	assign fold_lo = {1'b0, word_sum[15:0]} + {13'd0, word_sum[19:16]};
	assign fold_hi = fold_lo[15:0] + {15'd0, fold_lo[16]};

	always_ff @(posedge tx_clk) begin
		if (sys_rst)
			ip_cks <= '0;
		else if (frame_start)
			ip_cks <= ~fold_hi;
	end

	// ---------------------------------------------------------------------
	// Header byte lookup
	// ---------------------------------------------------------------------

	// Byte 0 sits in the top bits
	assign hdr_vec = {
		dst_mac, src_mac, 16'h0800,
		16'h4500, `UDP_TX_IP_LEN, 16'h0000, 16'h4000,
		`UDP_TX_TTL, 8'h11, ip_cks, src_ip, dst_ip,
		`UDP_TX_SPORT, `UDP_TX_DPORT, `UDP_TX_UDP_LEN, 16'h0000
	};

	always_comb begin
		if (hdr_idx <= udp_tx_pkg::hdr_idx_t'(41))
			hdr_byte = hdr_vec[(41 - int'(hdr_idx)) * 8 +: 8];
		else
			hdr_byte = '0;
	end

endmodule

`default_nettype wire

// File: logic/sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_defs.svh"

module sample_packer (
	input  wire logic                tx_clk,
	input  wire logic                sys_rst,
	input  wire logic                pay_arm,
	input  wire logic                pay_adv,
	input  wire udp_tx_pkg::sample_t sample,
	output logic                     rd_en,
	output udp_tx_pkg::byte_t        pay_byte
);

	logic [1:0]           phase;
	logic                 rd_second;
	logic                 pair_start;
	udp_tx_pkg::pay_cnt_t pairs_left;
	udp_tx_pkg::sample_t  swap;

	// First read of a pair; the second follows on its own
	assign pair_start = pay_arm ||
		(pay_adv && phase == 2'd1 && pairs_left != '0);

	always_ff @(posedge tx_clk) begin
		if (sys_rst) begin
			phase      <= 2'd0;
			rd_en      <= 1'b0;
			rd_second  <= 1'b0;
			pairs_left <= '0;
		end else begin
			rd_en     <= pair_start || (rd_en && !rd_second);
			rd_second <= rd_en && !rd_second;
			if (pay_arm) begin
				phase      <= 2'd0;
				pairs_left <= udp_tx_pkg::pay_cnt_t'(`UDP_TX_PAYLOAD_BYTES / 3 - 1);
			end else begin
				if (pay_adv)
					phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
				if (pair_start)
					pairs_left <= pairs_left - 1'b1;
			end
		end
	end

	// Hold s0 high nibble, then s1 high byte
	always_ff @(posedge tx_clk) begin
		if (pay_adv && phase == 2'd0)
			swap[3:0] <= sample[11:8];
		if (pay_adv && phase == 2'd1)
			swap[11:4] <= sample[11:4];
	end

	always_comb begin
		case (phase)
			2'd0:    pay_byte = sample[7:0];
			2'd1:    pay_byte = {swap[3:0], sample[3:0]};
			2'd2:    pay_byte = swap[11:4];
			default: pay_byte = '0;
		endcase
	end

	a_rd_pairs: assert property (@(posedge tx_clk) disable iff (sys_rst)
		rd_en && rd_second |=> !rd_en);

endmodule

`default_nettype wire

// File: logic/udp_tx_defs.svh
`ifndef UDP_TX_DEFS_SVH
`define UDP_TX_DEFS_SVH

// ---------------------------------------------------------------------
// Station addressing
// ---------------------------------------------------------------------

// Base addresses whose low byte is adjusted by the station id
`define UDP_TX_DST_MAC 48'h00_23_45_67_89_02
`define UDP_TX_SRC_MAC 48'h00_23_45_67_89_01
`define UDP_TX_DST_IP  {8'd192, 8'd168, 8'd0, 8'd2}
`define UDP_TX_SRC_IP  {8'd192, 8'd168, 8'd0, 8'd1}

`define UDP_TX_SPORT 16'd12346
`define UDP_TX_DPORT 16'd12346
`define UDP_TX_TTL   8'h40

// ---------------------------------------------------------------------
// Frame geometry
// ---------------------------------------------------------------------

// A multiple of three since two samples fill three bytes
`define UDP_TX_PAYLOAD_BYTES 1332

// IPv4 and UDP length fields
`define UDP_TX_IP_LEN  16'(28 + `UDP_TX_PAYLOAD_BYTES)
`define UDP_TX_UDP_LEN 16'(8 + `UDP_TX_PAYLOAD_BYTES)

`define UDP_TX_PREAMBLE_LEN 7
`define UDP_TX_IFG_CYCLES   12

`endif

// File: logic/udp_tx_pkg.sv
`default_nettype none

package udp_tx_pkg;

	// -----------------------------------------------------------------
	// Vector types
	// -----------------------------------------------------------------

	typedef logic [7:0]  byte_t;
	typedef logic [11:0] sample_t;
	typedef logic [31:0] crc_t;

	// Header byte 0 to 41
	typedef logic [5:0]  hdr_idx_t;

	// Wide enough for the payload and all other section counts
	typedef logic [10:0] pay_cnt_t;

	// One byte on the internal stream
	typedef struct packed {
		logic  en;
		logic  crc_first;
		byte_t data;
	} tx_beat_t;

	// Frame sections in transmit order
	typedef enum logic [2:0] {
		seq_idle,
		seq_preamble,
		seq_sfd,
		seq_header,
		seq_payload,
		seq_gap
	} seq_state_e;

endpackage

`default_nettype wire

// File: sim/tb_gmii_udp_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_defs.svh"

module tb_gmii_udp_tx;

	localparam int N_TESTS    = 4;
	localparam int MEM_WORDS  = 8192;
	localparam int FRAME_LEN  = 54 + `UDP_TX_PAYLOAD_BYTES;
	localparam int FRAME_RDS  = `UDP_TX_PAYLOAD_BYTES / 3 * 2;
	localparam int WAIT_LIMIT = 200;

	logic                tx_clk;
	logic                sys_rst;
	logic                id;
	logic                empty;
	udp_tx_pkg::sample_t sample;
	logic                rd_en;
	logic                tx_en;
	udp_tx_pkg::byte_t   txd;

	udp_tx_pkg::sample_t fifo_mem [0:MEM_WORDS-1];
	udp_tx_pkg::byte_t   exp_frame [0:2047];
	udp_tx_pkg::byte_t   cap_frame [0:2047];
	udp_tx_pkg::crc_t    exp_fcs;
	int                  rd_ptr = 0;
	logic                rd_pend = 1'b0;

	// Test table of name, station id, start delay, frame count and expected tx_en cycles
	string t_name   [0:N_TESTS-1] = '{"idle_empty", "id0_frame", "id1_frame", "back_to_back"};
	logic  t_id     [0:N_TESTS-1] = '{1'b0, 1'b0, 1'b1, 1'b0};
	int    t_delay  [0:N_TESTS-1] = '{60, 5, 3, 0};
	int    t_frames [0:N_TESTS-1] = '{0, 1, 1, 3};
	int    t_len    [0:N_TESTS-1] = '{0, FRAME_LEN, FRAME_LEN, FRAME_LEN};

	int          err_cnt = 0;
	int          check_cnt = 0;
	int          test_err;
	int          frame_base = 0;
	int          high_cnt;
	int          gap;
	int          len;
	int          rd_start;
	bit          ok;
	bit          timed_out = 1'b0;
	logic [31:0] seed;

	gmii_udp_tx i_dut (
		.tx_clk, .sys_rst, .id, .sample, .empty, .rd_en, .tx_en, .txd
	);

	initial begin
		tx_clk = 1'b0;
		forever #50 tx_clk = ~tx_clk;
	end

	// FIFO model with data in the cycle after the read strobe
	always @(negedge tx_clk) begin
		if (rd_pend) begin
			sample <= fifo_mem[rd_ptr % MEM_WORDS];
			rd_ptr <= rd_ptr + 1;
		end
		rd_pend <= rd_en;
	end

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] ip_checksum(input int off);
		logic [31:0] sum;
		sum = '0;
		for (int w = 0; w < 10; w++)
			sum = sum + {16'd0, exp_frame[off + 2 * w], exp_frame[off + 2 * w + 1]};
		while (sum[31:16] != 16'd0)
			sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
		return ~sum[15:0];
	endfunction

	function automatic udp_tx_pkg::crc_t crc32_ref(input int first, input int last);
		udp_tx_pkg::crc_t c;
		c = 32'hffffffff;
		for (int n = first; n <= last; n++) begin
			c = c ^ {24'd0, exp_frame[n]};
			for (int b = 0; b < 8; b++)
				c = (c >> 1) ^ (32'hedb88320 & {32{c[0]}});
		end
		return ~c;
	endfunction

	// Most significant byte first
	task automatic put_field(inout int pos, input logic [47:0] v, input int n);
		for (int i = n - 1; i >= 0; i--) begin
			exp_frame[pos] = v[i * 8 +: 8];
			pos++;
		end
	endtask

	task automatic build_frame(input logic sid, input int base);
		logic [47:0]         dmac;
		logic [47:0]         smac;
		logic [31:0]         dip;
		logic [31:0]         sip;
		logic [15:0]         cks;
		udp_tx_pkg::sample_t s0;
		udp_tx_pkg::sample_t s1;
		int                  pos;
		dmac = `UDP_TX_DST_MAC;
		smac = `UDP_TX_SRC_MAC;
		dip = `UDP_TX_DST_IP;
		sip = `UDP_TX_SRC_IP;
		dmac[7:0] = dmac[7:0] - sid;
		smac[7:0] = smac[7:0] + sid;
		dip[7:0] = dip[7:0] - sid;
		sip[7:0] = sip[7:0] + sid;
		pos = 0;
		for (int i = 0; i < `UDP_TX_PREAMBLE_LEN; i++)
			put_field(pos, 48'h55, 1);
		put_field(pos, 48'hd5, 1);
		put_field(pos, dmac, 6);
		put_field(pos, smac, 6);
		put_field(pos, 48'h0800, 2);
		put_field(pos, 48'h4500, 2);
		put_field(pos, `UDP_TX_IP_LEN, 2);
		put_field(pos, 48'h0000, 2);
		put_field(pos, 48'h4000, 2);
		put_field(pos, `UDP_TX_TTL, 1);
		put_field(pos, 48'h11, 1);
		put_field(pos, 48'h0000, 2);
		put_field(pos, sip, 4);
		put_field(pos, dip, 4);
		put_field(pos, `UDP_TX_SPORT, 2);
		put_field(pos, `UDP_TX_DPORT, 2);
		put_field(pos, `UDP_TX_UDP_LEN, 2);
		put_field(pos, 48'h0000, 2);
		// IPv4 header starts after preamble, SFD and Ethernet header
		cks = ip_checksum(22);
		exp_frame[32] = cks[15:8];
		exp_frame[33] = cks[7:0];
		for (int k = 0; k < `UDP_TX_PAYLOAD_BYTES / 3; k++) begin
			s0 = fifo_mem[(base + 2 * k) % MEM_WORDS];
			s1 = fifo_mem[(base + 2 * k + 1) % MEM_WORDS];
			put_field(pos, s0[7:0], 1);
			put_field(pos, {s0[11:8], s1[3:0]}, 1);
			put_field(pos, s1[11:4], 1);
		end
		exp_fcs = crc32_ref(8, pos - 1);
	endtask

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------

	task automatic check_byte(input string name, input int idx,
		input udp_tx_pkg::byte_t exp, input udp_tx_pkg::byte_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			test_err++;
			$display("** Error: %s byte %0d expected %02h actual %02h", name, idx, exp, act);
		end
	endtask

	task automatic check_crc(input string name,
		input udp_tx_pkg::crc_t exp, input udp_tx_pkg::crc_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			test_err++;
			$display("** Error: %s fcs expected %08h actual %08h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input string what,
		input udp_tx_pkg::pay_cnt_t exp, input udp_tx_pkg::pay_cnt_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			test_err++;
			$display("** Error: %s %s expected %0d actual %0d", name, what, exp, act);
		end
	endtask

	// ------------------------------------------------------------------
	// Waits on the GMII side
	// ------------------------------------------------------------------

	task automatic wait_tx(input logic level, input int limit, output int cycles, output bit done);
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < limit) begin
			@(negedge tx_clk);
			if (tx_en == level)
				done = 1'b1;
			else
				cycles++;
		end
	endtask

	// Entered on the first byte and left on the first low cycle
	task automatic capture_frame(output int n, output bit done);
		n = 0;
		done = 1'b0;
		while (!done && n < 2048) begin
			cap_frame[n] = txd;
			n++;
			@(negedge tx_clk);
			if (!tx_en)
				done = 1'b1;
		end
	endtask

	initial begin
		seed = 32'h1ca64f30;
		for (int i = 0; i < MEM_WORDS; i++) begin
			seed = lcg_next(seed);
			fifo_mem[i] = seed[27:16];
		end

		sys_rst = 1'b1;
		empty = 1'b1;
		id = 1'b0;
		sample = '0;
		repeat (16) @(negedge tx_clk);
		sys_rst = 1'b0;

		for (int t = 0; t < N_TESTS && !timed_out; t++) begin
			test_err = 0;
			id = t_id[t];
			if (t_frames[t] == 0) begin
				high_cnt = 0;
				repeat (t_delay[t]) begin
					@(negedge tx_clk);
					if (tx_en)
						high_cnt++;
				end
				check_count(t_name[t], "tx_en cycles", udp_tx_pkg::pay_cnt_t'(t_len[t]),
					udp_tx_pkg::pay_cnt_t'(high_cnt));
			end else begin
				repeat (t_delay[t]) @(negedge tx_clk);
				empty = 1'b0;
				wait_tx(1'b1, WAIT_LIMIT, gap, ok);
				for (int f = 0; f < t_frames[t] && ok; f++) begin
					// First low cycle is seen by capture_frame
					if (f > 0 && gap + 1 < `UDP_TX_IFG_CYCLES) begin
						err_cnt++;
						test_err++;
						$display("** Error: %s gap expected at least %0d actual %0d",
							t_name[t], `UDP_TX_IFG_CYCLES, gap + 1);
					end
					rd_start = rd_ptr;
					build_frame(t_id[t], frame_base);
					capture_frame(len, ok);
					if (f == t_frames[t] - 1)
						empty = 1'b1;
					if (!ok) begin
						$display("%s: tx_en did not fall at the end of frame %0d", t_name[t], f);
					end else begin
						check_count(t_name[t], "frame length", udp_tx_pkg::pay_cnt_t'(t_len[t]),
							udp_tx_pkg::pay_cnt_t'(len));
						check_count(t_name[t], "fifo reads", udp_tx_pkg::pay_cnt_t'(FRAME_RDS),
							udp_tx_pkg::pay_cnt_t'(rd_ptr - rd_start));
						for (int i = 0; i < FRAME_LEN - 4 && i < len; i++)
							check_byte(t_name[t], i, exp_frame[i], cap_frame[i]);
						if (len == FRAME_LEN)
							check_crc(t_name[t], exp_fcs, {cap_frame[FRAME_LEN - 1],
								cap_frame[FRAME_LEN - 2], cap_frame[FRAME_LEN - 3],
								cap_frame[FRAME_LEN - 4]});
						frame_base += FRAME_RDS;
						if (f < t_frames[t] - 1) begin
							wait_tx(1'b1, WAIT_LIMIT, gap, ok);
							if (!ok)
								$display("%s: next frame did not start in time", t_name[t]);
						end
					end
				end
				if (!ok) begin
					$display("%s: timed out waiting for tx_en", t_name[t]);
					timed_out = 1'b1;
				end
			end
			$display("%-14s frames %0d, errors %0d", t_name[t], t_frames[t], test_err);
		end

		$display("checks %0d, errors %0d, timeout %0d", check_cnt, err_cnt, timed_out);
		if (err_cnt == 0 && !timed_out) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
